// ==== flist.f ====
logic/bus_pkg.sv
logic/cache_pkg.sv
logic/icache.sv
logic/dcache.sv
logic/mem_arbiter.sv
logic/main_memory.sv
logic/mem_subsystem_top.sv
tb/mem_checker.sv
tb/tb_top.sv

// ==== tb/tb_top.sv ====
module tb_top;

    localparam int INDEX_BITS  = cache_pkg::DEF_INDEX_BITS;
    localparam int MEM_WORDS   = cache_pkg::DEF_MEM_WORDS;
    localparam int MEM_LATENCY = 3;
    localparam int TIMEOUT     = 200;
    localparam int HALF_WORDS  = MEM_WORDS / 2;
    localparam int RANDOM_OPS  = 300;

    logic                       clk = 1'b0;
    logic                       rst;
    logic [bus_pkg::ADDR_W-1:0] i_addr;
    logic                       i_valid;
    logic [bus_pkg::DATA_W-1:0] i_rdata;
    logic                       i_ready;
    logic [bus_pkg::ADDR_W-1:0] d_addr;
    logic                       d_valid;
    logic                       d_wr;
    logic [bus_pkg::DATA_W-1:0] d_wdata;
    logic [bus_pkg::DATA_W-1:0] d_rdata;
    logic                       d_ready;

    int    check_errors;
    int    reads_checked;
    int    fail_count;
    int    cycles_a;
    int    cycles_b;
    string test_name;

    always #4 clk = ~clk;

    mem_subsystem_top #(
        .INDEX_BITS  (INDEX_BITS),
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) uut (
        .clk     (clk),
        .rst     (rst),
        .i_addr  (i_addr),
        .i_valid (i_valid),
        .i_rdata (i_rdata),
        .i_ready (i_ready),
        .d_addr  (d_addr),
        .d_valid (d_valid),
        .d_wr    (d_wr),
        .d_wdata (d_wdata),
        .d_rdata (d_rdata),
        .d_ready (d_ready)
    );

    mem_checker #(
        .MEM_WORDS (MEM_WORDS)
    ) u_checker (
        .clk         (clk),
        .rst         (rst),
        .i_addr      (i_addr),
        .i_rdata     (i_rdata),
        .i_ready     (i_ready),
        .d_addr      (d_addr),
        .d_wr        (d_wr),
        .d_wdata     (d_wdata),
        .d_rdata     (d_rdata),
        .d_ready     (d_ready),
        .error_count (check_errors),
        .read_count  (reads_checked)
    );

    task begin_test(input string name);
        test_name = name;
        u_checker.start_test(name);
    endtask

    function automatic logic [bus_pkg::ADDR_W-1:0] word_to_addr(input int word);
        return bus_pkg::ADDR_W'(word) << bus_pkg::WORD_OFF_BITS;
    endfunction

    task automatic instr_read(input logic [bus_pkg::ADDR_W-1:0] addr, output int cycles);
        int n;
        @(posedge clk);
        i_addr  <= addr;
        i_valid <= 1'b1;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (i_ready !== 1'b1 && n < TIMEOUT);
        if (i_ready !== 1'b1)
        begin
            $display("timeout in %s: instruction port gave no ready within %0d cycles",
                     test_name, TIMEOUT);
            fail_count++;
        end
        @(posedge clk);
        i_valid <= 1'b0;
        cycles = n;
    endtask

    task automatic data_access(
        input  logic                       wr,
        input  logic [bus_pkg::ADDR_W-1:0] addr,
        input  logic [bus_pkg::DATA_W-1:0] wdata,
        output int                         cycles
    );
        int n;
        @(posedge clk);
        d_addr  <= addr;
        d_wr    <= wr;
        d_wdata <= wdata;
        d_valid <= 1'b1;
        n = 0;
        do
        begin
            @(negedge clk);
            n++;
        end
        while (d_ready !== 1'b1 && n < TIMEOUT);
        if (d_ready !== 1'b1)
        begin
            $display("timeout in %s: data port gave no ready within %0d cycles",
                     test_name, TIMEOUT);
            fail_count++;
        end
        @(posedge clk);
        d_valid <= 1'b0;
        cycles = n;
    endtask

    task automatic expect_hit(input int cycles);
        if (cycles != 2)
        begin
            $display("error %s: hit latency expected 2 actual %0d", test_name, cycles);
            fail_count++;
        end
    endtask

    task automatic expect_miss(input int cycles);
        if (cycles <= 2)
        begin
            $display("error %s: miss latency expected above 2 actual %0d", test_name, cycles);
            fail_count++;
        end
    endtask

    task automatic check_ready_low();
        if (i_ready !== 1'b0 || d_ready !== 1'b0)
        begin
            $display("error %s: ready expected 0 0 actual %b %b", test_name, i_ready, d_ready);
            fail_count++;
        end
    endtask

    task automatic random_instr_traffic();
        int cycles;
        for (int i = 0; i < RANDOM_OPS; i++)
            instr_read(word_to_addr($urandom % 64), cycles);
    endtask

    task automatic random_data_traffic();
        int cycles;
        for (int i = 0; i < RANDOM_OPS; i++)
            data_access(1'($urandom % 2), word_to_addr(HALF_WORDS + $urandom % 64), $urandom,
                        cycles);
    endtask

    initial
    begin
        logic [bus_pkg::ADDR_W-1:0] addr_a;
        logic [bus_pkg::ADDR_W-1:0] addr_b;
        void'($urandom(32'h738d));
        fail_count = 0;
        rst        = 1'b1;
        i_addr     = '0;
        i_valid    = 1'b0;
        d_addr     = '0;
        d_valid    = 1'b0;
        d_wr       = 1'b0;
        d_wdata    = '0;

        begin_test("reset");
        repeat (5)
        begin
            @(negedge clk);
            check_ready_low();
        end
        @(posedge clk);
        rst <= 1'b0;
        repeat (3)
        begin
            @(negedge clk);
            check_ready_low();
        end

        begin_test("instr_read");
        instr_read(word_to_addr(16), cycles_a);
        expect_miss(cycles_a);
        instr_read(word_to_addr(16), cycles_a);
        expect_hit(cycles_a);

        begin_test("data_write_read");
        data_access(1'b1, word_to_addr(HALF_WORDS + 3), 32'h1234_abcd, cycles_a);
        data_access(1'b0, word_to_addr(HALF_WORDS + 3), '0, cycles_a);
        expect_hit(cycles_a);

        // b maps to the same line as a with a different tag
        begin_test("dirty_eviction");
        addr_a = word_to_addr(HALF_WORDS + 5);
        addr_b = word_to_addr(HALF_WORDS + 5 + (1 << INDEX_BITS));
        data_access(1'b1, addr_a, 32'h5a5a_0f0f, cycles_a);
        data_access(1'b0, addr_b, '0, cycles_a);
        expect_miss(cycles_a);
        data_access(1'b0, addr_a, '0, cycles_a);
        expect_miss(cycles_a);

        begin_test("contention");
        fork
            instr_read(word_to_addr(37), cycles_a);
            data_access(1'b0, word_to_addr(HALF_WORDS + 48), '0, cycles_b);
        join
        expect_miss(cycles_a);
        expect_miss(cycles_b);
        // data side owns the port first when both miss together
        if (cycles_b >= cycles_a)
        begin
            $display("error %s: data ready first expected, actual data %0d instr %0d cycles",
                     test_name, cycles_b, cycles_a);
            fail_count++;
        end

        begin_test("random_traffic");
        fork
            random_instr_traffic();
            random_data_traffic();
        join

        repeat (4) @(posedge clk);
        $display("errors: checker %0d, testbench %0d, reads checked %0d",
                 check_errors, fail_count, reads_checked);
        if (check_errors == 0 && fail_count == 0 && reads_checked > 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== tb/mem_checker.sv ====
module mem_checker #(
    parameter int MEM_WORDS = cache_pkg::DEF_MEM_WORDS
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [bus_pkg::ADDR_W-1:0] i_addr,
    input  logic [bus_pkg::DATA_W-1:0] i_rdata,
    input  logic                       i_ready,
    input  logic [bus_pkg::ADDR_W-1:0] d_addr,
    input  logic                       d_wr,
    input  logic [bus_pkg::DATA_W-1:0] d_wdata,
    input  logic [bus_pkg::DATA_W-1:0] d_rdata,
    input  logic                       d_ready,
    output int                         error_count,
    output int                         read_count
);

    localparam int WORD_BITS = $clog2(MEM_WORDS);
    localparam int OFF       = bus_pkg::WORD_OFF_BITS;

    // shadow of main memory, only words the data port has written
    logic [bus_pkg::DATA_W-1:0] shadow [MEM_WORDS];
    logic                       written [MEM_WORDS];
    string                      test_name;

    initial
    begin
        error_count = 0;
        read_count  = 0;
        test_name   = "none";
        for (int i = 0; i < MEM_WORDS; i++)
            written[i] = 1'b0;
    end

    task start_test(input string name);
        test_name = name;
    endtask

    function automatic logic [bus_pkg::DATA_W-1:0] expected_word(
        input logic [bus_pkg::ADDR_W-1:0] addr
    );
        logic [WORD_BITS-1:0] word;
        word = addr[OFF +: WORD_BITS];
        if (written[word])
            return shadow[word];
        return bus_pkg::pattern_word(bus_pkg::ADDR_W'(word));
    endfunction

    task automatic compare_read(
        input string                      port,
        input logic [bus_pkg::ADDR_W-1:0] addr,
        input logic [bus_pkg::DATA_W-1:0] actual
    );
        logic [bus_pkg::DATA_W-1:0] expected;
        expected = expected_word(addr);
        read_count++;
        if (actual !== expected)
        begin
            $display("error %s: %s read at %h expected %h actual %h",
                     test_name, port, addr, expected, actual);
            error_count++;
        end
    endtask

    // outputs settle between edges, so look at them on the falling edge
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (i_ready === 1'b1)
                compare_read("instr", i_addr, i_rdata);
            if (d_ready === 1'b1 && d_wr)
            begin
                shadow[d_addr[OFF +: WORD_BITS]]  = d_wdata;
                written[d_addr[OFF +: WORD_BITS]] = 1'b1;
            end
            else if (d_ready === 1'b1)
                compare_read("data", d_addr, d_rdata);
        end
    end

endmodule

// ==== logic/mem_subsystem_top.sv ====
module mem_subsystem_top #(
    parameter int INDEX_BITS  = cache_pkg::DEF_INDEX_BITS,
    parameter int MEM_WORDS   = cache_pkg::DEF_MEM_WORDS,
    parameter int MEM_LATENCY = 3
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [bus_pkg::ADDR_W-1:0] i_addr,
    input  logic                       i_valid,
    output logic [bus_pkg::DATA_W-1:0] i_rdata,
    output logic                       i_ready,
    input  logic [bus_pkg::ADDR_W-1:0] d_addr,
    input  logic                       d_valid,
    input  logic                       d_wr,
    input  logic [bus_pkg::DATA_W-1:0] d_wdata,
    output logic [bus_pkg::DATA_W-1:0] d_rdata,
    output logic                       d_ready
);

    bus_pkg::mem_req_t i_mem_req;
    bus_pkg::mem_rsp_t i_mem_rsp;
    bus_pkg::mem_req_t d_mem_req;
    bus_pkg::mem_rsp_t d_mem_rsp;
    bus_pkg::mem_req_t arb_req;
    bus_pkg::mem_rsp_t arb_rsp;

    icache #(
        .INDEX_BITS (INDEX_BITS),
        .MEM_WORDS  (MEM_WORDS)
    ) u_icache (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (i_addr),
        .cpu_valid (i_valid),
        .cpu_rdata (i_rdata),
        .cpu_ready (i_ready),
        .mem_req   (i_mem_req),
        .mem_rsp   (i_mem_rsp)
    );

    dcache #(
        .INDEX_BITS (INDEX_BITS),
        .MEM_WORDS  (MEM_WORDS)
    ) u_dcache (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (d_addr),
        .cpu_valid (d_valid),
        .cpu_wr    (d_wr),
        .cpu_wdata (d_wdata),
        .cpu_rdata (d_rdata),
        .cpu_ready (d_ready),
        .mem_req   (d_mem_req),
        .mem_rsp   (d_mem_rsp)
    );

    mem_arbiter u_arbiter (
        .clk     (clk),
        .rst     (rst),
        .i_req   (i_mem_req),
        .i_rsp   (i_mem_rsp),
        .d_req   (d_mem_req),
        .d_rsp   (d_mem_rsp),
        .mem_req (arb_req),
        .mem_rsp (arb_rsp)
    );

    main_memory #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) u_memory (
        .clk (clk),
        .rst (rst),
        .req (arb_req),
        .rsp (arb_rsp)
    );

endmodule

// ==== logic/main_memory.sv ====
module main_memory #(
    parameter int MEM_WORDS   = cache_pkg::DEF_MEM_WORDS,
    parameter int MEM_LATENCY = 3
) (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::mem_req_t req,
    output bus_pkg::mem_rsp_t rsp
);

    localparam int WORD_BITS = $clog2(MEM_WORDS);
    localparam int CNT_W     = $clog2(MEM_LATENCY + 1);

    logic [bus_pkg::DATA_W-1:0] mem [MEM_WORDS];
    logic [CNT_W-1:0]           count;
    logic                       rsp_ready;
    logic [bus_pkg::DATA_W-1:0] rsp_rdata;
    logic [WORD_BITS-1:0]       word_addr;
    logic                       done;

    initial
    begin
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = bus_pkg::pattern_word(bus_pkg::ADDR_W'(i));
    end

    assign word_addr = req.addr[bus_pkg::WORD_OFF_BITS +: WORD_BITS];
    assign done      = req.valid && !rsp_ready && (count == CNT_W'(MEM_LATENCY - 1));
    assign rsp       = '{ready: rsp_ready, rdata: rsp_rdata};

    // latency count, restarts after each ready pulse
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            count     <= '0;
            rsp_ready <= 1'b0;
        end
        else if (rsp_ready || !req.valid)
        begin
            count     <= '0;
            rsp_ready <= 1'b0;
        end
        else if (done)
        begin
            count     <= '0;
            rsp_ready <= 1'b1;
        end
        else
            count <= count + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (done)
        begin
            if (req.wr)
                mem[word_addr] <= req.wdata;
            else
                rsp_rdata <= mem[word_addr];
        end
    end

endmodule

// ==== logic/mem_arbiter.sv ====
module mem_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::mem_req_t i_req,
    output bus_pkg::mem_rsp_t i_rsp,
    input  bus_pkg::mem_req_t d_req,
    output bus_pkg::mem_rsp_t d_rsp,
    output bus_pkg::mem_req_t mem_req,
    input  bus_pkg::mem_rsp_t mem_rsp
);

    typedef enum logic [1:0] {
        grant_none,
        grant_instr,
        grant_data
    } grant_e;

    grant_e grant;

    // data side first when both ask while idle
    always_ff @(posedge clk)
    begin
        if (rst)
            grant <= grant_none;
        else
        begin
            case (grant)
                grant_none:
                begin
                    if (d_req.valid)
                        grant <= grant_data;
                    else if (i_req.valid)
                        grant <= grant_instr;
                end
                default:
                begin
                    // owner keeps the port until the memory answers
                    if (mem_rsp.ready)
                        grant <= grant_none;
                end
            endcase
        end
    end

    always_comb
    begin
        case (grant)
            grant_data:  mem_req = d_req;
            grant_instr: mem_req = i_req;
            default:     mem_req = '0;
        endcase

        i_rsp.rdata = mem_rsp.rdata;
        i_rsp.ready = mem_rsp.ready && (grant == grant_instr);
        d_rsp.rdata = mem_rsp.rdata;
        d_rsp.ready = mem_rsp.ready && (grant == grant_data);
    end

endmodule

// ==== logic/dcache.sv ====
module dcache #(
    parameter int INDEX_BITS = cache_pkg::DEF_INDEX_BITS,
    parameter int MEM_WORDS  = cache_pkg::DEF_MEM_WORDS
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [bus_pkg::ADDR_W-1:0] cpu_addr,
    input  logic                       cpu_valid,
    input  logic                       cpu_wr,
    input  logic [bus_pkg::DATA_W-1:0] cpu_wdata,
    output logic [bus_pkg::DATA_W-1:0] cpu_rdata,
    output logic                       cpu_ready,
    output bus_pkg::mem_req_t          mem_req,
    input  bus_pkg::mem_rsp_t          mem_rsp
);

    localparam int LINES     = 1 << INDEX_BITS;
    localparam int WORD_BITS = $clog2(MEM_WORDS);
    localparam int TAG_BITS  = WORD_BITS - INDEX_BITS;
    localparam int OFF       = bus_pkg::WORD_OFF_BITS;
    localparam int PAD_BITS  = bus_pkg::ADDR_W - WORD_BITS - OFF;

    cache_pkg::cache_state_e state;

    cache_pkg::line_flags_t [LINES-1:0] flags;
    logic [TAG_BITS-1:0]        tag_mem [LINES];
    logic [bus_pkg::DATA_W-1:0] data_mem [LINES];

    logic [INDEX_BITS-1:0]      index;
    logic [TAG_BITS-1:0]        tag;
    logic                       hit;
    logic                       req_valid;
    logic                       evicting;
    logic [bus_pkg::ADDR_W-1:0] fill_addr;
    logic [bus_pkg::ADDR_W-1:0] victim_addr;

    assign index = cpu_addr[OFF +: INDEX_BITS];
    assign tag   = cpu_addr[OFF + INDEX_BITS +: TAG_BITS];
    assign hit   = flags[index].valid && (tag_mem[index] == tag);

    assign cpu_ready = (state == cache_pkg::compare_tag) && hit;
    assign cpu_rdata = data_mem[index];

    assign fill_addr   = {cpu_addr[bus_pkg::ADDR_W-1:OFF], {OFF{1'b0}}};
    // victim address rebuilt from the stored tag and the index
    assign victim_addr = {{PAD_BITS{1'b0}}, tag_mem[index], index, {OFF{1'b0}}};
    assign evicting    = (state == cache_pkg::write_back);

    assign mem_req = '{
        valid: req_valid,
        wr:    evicting,
        addr:  evicting ? victim_addr : fill_addr,
        wdata: data_mem[index]
    };

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= cache_pkg::idle;
            flags     <= '0;
            req_valid <= 1'b0;
        end
        else
        begin
            case (state)
                cache_pkg::idle:
                begin
                    if (cpu_valid)
                        state <= cache_pkg::compare_tag;
                end
                cache_pkg::compare_tag:
                begin
                    if (hit)
                    begin
                        if (cpu_wr)
                            flags[index].dirty <= 1'b1;
                        state <= cache_pkg::idle;
                    end
                    else if (flags[index].valid && flags[index].dirty)
                        state <= cache_pkg::write_back;
                    else
                        state <= cache_pkg::allocate;
                end
                cache_pkg::write_back:
                begin
                    if (mem_rsp.ready)
                    begin
                        req_valid <= 1'b0;
                        state     <= cache_pkg::allocate;
                    end
                    else if (!req_valid)
                        req_valid <= 1'b1;
                end
                cache_pkg::allocate:
                begin
                    if (mem_rsp.ready)
                    begin
                        flags[index] <= '{valid: 1'b1, dirty: 1'b0};
                        req_valid    <= 1'b0;
                        state        <= cache_pkg::compare_tag;
                    end
                    else if (!req_valid)
                        req_valid <= 1'b1;
                end
                default: state <= cache_pkg::idle;
            endcase
        end
    end

    // fill on allocate, cpu word on a write hit
    always_ff @(posedge clk)
    begin
        if (state == cache_pkg::allocate && mem_rsp.ready)
        begin
            tag_mem[index]  <= tag;
            data_mem[index] <= mem_rsp.rdata;
        end
        else if (cpu_ready && cpu_wr)
            data_mem[index] <= cpu_wdata;
    end

endmodule

// ==== logic/icache.sv ====
module icache #(
    parameter int INDEX_BITS = cache_pkg::DEF_INDEX_BITS,
    parameter int MEM_WORDS  = cache_pkg::DEF_MEM_WORDS
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [bus_pkg::ADDR_W-1:0] cpu_addr,
    input  logic                       cpu_valid,
    output logic [bus_pkg::DATA_W-1:0] cpu_rdata,
    output logic                       cpu_ready,
    output bus_pkg::mem_req_t          mem_req,
    input  bus_pkg::mem_rsp_t          mem_rsp
);

    localparam int LINES     = 1 << INDEX_BITS;
    localparam int WORD_BITS = $clog2(MEM_WORDS);
    localparam int TAG_BITS  = WORD_BITS - INDEX_BITS;
    localparam int OFF       = bus_pkg::WORD_OFF_BITS;

    cache_pkg::cache_state_e state;

    logic [LINES-1:0]          line_valid;
    logic [TAG_BITS-1:0]       tag_mem [LINES];
    logic [bus_pkg::DATA_W-1:0] data_mem [LINES];

    logic [INDEX_BITS-1:0]      index;
    logic [TAG_BITS-1:0]        tag;
    logic                       hit;
    logic                       req_valid;
    logic [bus_pkg::ADDR_W-1:0] fill_addr;

    assign index = cpu_addr[OFF +: INDEX_BITS];
    assign tag   = cpu_addr[OFF + INDEX_BITS +: TAG_BITS];
    assign hit   = line_valid[index] && (tag_mem[index] == tag);

    // ready only out of compare_tag, so one pulse per request
    assign cpu_ready = (state == cache_pkg::compare_tag) && hit;
    assign cpu_rdata = data_mem[index];

    // cpu holds the address, so the fill request stays stable
    assign fill_addr = {cpu_addr[bus_pkg::ADDR_W-1:OFF], {OFF{1'b0}}};

    assign mem_req = '{
        valid: req_valid,
        wr:    1'b0,
        addr:  fill_addr,
        wdata: '0
    };

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state      <= cache_pkg::idle;
            line_valid <= '0;
            req_valid  <= 1'b0;
        end
        else
        begin
            case (state)
                cache_pkg::idle:
                begin
                    if (cpu_valid)
                        state <= cache_pkg::compare_tag;
                end
                cache_pkg::compare_tag:
                begin
                    if (hit)
                        state <= cache_pkg::idle;
                    else
                        state <= cache_pkg::allocate;
                end
                cache_pkg::allocate:
                begin
                    if (mem_rsp.ready)
                    begin
                        line_valid[index] <= 1'b1;
                        req_valid         <= 1'b0;
                        state             <= cache_pkg::compare_tag;
                    end
                    else if (!req_valid)
                        req_valid <= 1'b1;
                end
                default: state <= cache_pkg::idle;
            endcase
        end
    end

    // line fill, tag taken from the missing address
    always_ff @(posedge clk)
    begin
        if (state == cache_pkg::allocate && mem_rsp.ready)
        begin
            tag_mem[index]  <= tag;
            data_mem[index] <= mem_rsp.rdata;
        end
    end

endmodule

// ==== logic/cache_pkg.sv ====
package cache_pkg;

    // default geometry, lines per cache are 2**DEF_INDEX_BITS
    localparam int DEF_INDEX_BITS = 4;

    // default memory depth in words, also fixes the tag width
    localparam int DEF_MEM_WORDS = 4096;

    // per-line status bits of the data cache
    typedef struct packed {
        logic valid;
        logic dirty;
    } line_flags_t;

    // shared by both caches, the icache never enters write_back
    typedef enum logic [1:0] {
        idle,
        compare_tag,
        write_back,
        allocate
    } cache_state_e;

endpackage

// ==== logic/bus_pkg.sv ====
package bus_pkg;

    // byte address and word widths of the shared memory port
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // byte offset bits below a word-aligned address
    localparam int WORD_OFF_BITS = 2;

    // request from a cache to the arbiter, and from the arbiter to the memory
    typedef struct packed {
        logic              valid;
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    // ready pulses once per request, rdata valid with it on reads
    typedef struct packed {
        logic              ready;
        logic [DATA_W-1:0] rdata;
    } mem_rsp_t;

    // power-on contents, low half of the word address and its inverse side by side
    function automatic logic [DATA_W-1:0] pattern_word(input logic [ADDR_W-1:0] word_addr);
        logic [DATA_W/2-1:0] low;
        low = word_addr[DATA_W/2-1:0];
        return {low, ~low};
    endfunction

endpackage
